// ==== all.f ====
rtl/lsu_pkg.sv
rtl/dbus_if.sv
rtl/lsu_serial_if.sv
rtl/lsu_mem_if.sv
rtl/lsu_sequencer.sv
rtl/data_ram.sv
rtl/serial_lsu_top.sv
test/tb_clock.sv
test/serial_lsu_assertions.sv
test/serial_lsu_tb.sv

// ==== rtl/data_ram.sv ====
`default_nettype none

module data_ram #(
   parameter int STALL_CYCLES = 2
) (
   input  wire          i_clk,
   input  wire          i_reset,
   dbus_if.slave        bus
);

   typedef logic [$clog2(STALL_CYCLES + 1)-1:0] stall_cnt_t;

   logic [lsu_pkg::XLEN-1:0]      mem [lsu_pkg::RAM_WORDS];
   logic [lsu_pkg::RAM_AW-1:0]    adr_q;
   logic                          rd_pend;
   logic                          wr_pend;
   logic                          cmd_seen;
   stall_cnt_t                    stall_cnt;
   logic                          ca_en;
   logic                          dm_en;
   logic                          rd_done;

   assign ca_en   = bus.ca_vld & bus.ca_rdy;
   assign dm_en   = bus.dm_vld & bus.dm_rdy;
   assign rd_done = rd_pend & (stall_cnt == '0);

   assign bus.ca_rdy = cmd_seen & !rd_pend & !wr_pend & !bus.rd_vld; // one access at a time
   assign bus.dm_rdy = wr_pend;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         rd_pend    <= 1'b0;
         wr_pend    <= 1'b0;
         cmd_seen   <= 1'b0;
         bus.rd_vld <= 1'b0;
      end else begin
         cmd_seen <= bus.ca_vld & !ca_en; // command held off one cycle
         if (ca_en) begin
            rd_pend <= !bus.ca_cmd;
            wr_pend <= bus.ca_cmd;
         end
         if (dm_en)
            wr_pend <= 1'b0;
         if (rd_done) begin
            rd_pend    <= 1'b0;
            bus.rd_vld <= 1'b1;
         end else if (bus.rd_vld & bus.rd_rdy) begin
            bus.rd_vld <= 1'b0;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (ca_en) begin
         adr_q     <= bus.ca_adr[lsu_pkg::RAM_AW+1:2];
         stall_cnt <= stall_cnt_t'(STALL_CYCLES - 1);
      end else if (rd_pend) begin
         stall_cnt <= stall_cnt - 1'b1;
      end

      if (dm_en) begin
         for (int i = 0; i < lsu_pkg::BYTES; i++) begin
            if (bus.dm_msk[i])
               mem[adr_q][8*i +: 8] <= bus.dm_dat[8*i +: 8];
         end
      end

      if (rd_done)
         bus.rd_dat <= mem[adr_q]; // held until next read
   end

endmodule

`default_nettype wire

// ==== rtl/dbus_if.sv ====
`default_nettype none

interface dbus_if;

   // command channel
   logic                          ca_cmd;  // 1 = store
   logic [lsu_pkg::XLEN-1:0]      ca_adr;
   logic                          ca_vld;
   logic                          ca_rdy;

   // write data channel
   logic [lsu_pkg::XLEN-1:0]      dm_dat;
   logic [lsu_pkg::BYTES-1:0]     dm_msk;
   logic                          dm_vld;
   logic                          dm_rdy;

   // read data channel
   logic [lsu_pkg::XLEN-1:0]      rd_dat;
   logic                          rd_vld;
   logic                          rd_rdy;

   modport master (
      output ca_cmd, ca_adr, ca_vld, dm_dat, dm_msk, dm_vld, rd_rdy,
      input  ca_rdy, dm_rdy, rd_dat, rd_vld
   );

   modport slave (
      input  ca_cmd, ca_adr, ca_vld, dm_dat, dm_msk, dm_vld, rd_rdy,
      output ca_rdy, dm_rdy, rd_dat, rd_vld
   );

endinterface

`default_nettype wire

// ==== rtl/lsu_mem_if.sv ====
`default_nettype none

module lsu_mem_if (
   input  wire          i_clk,
   input  wire          i_reset,
   lsu_serial_if.mem    ser,
   dbus_if.master       bus
);

   logic                          ca_en;
   logic                          dm_en;
   logic                          rd_en;
   logic                          init_r;
   logic                          init_fall;
   logic                          carry;
   logic                          sum;
   logic                          signbit;
   logic [lsu_pkg::XLEN-1:0]      adr;
   logic [lsu_pkg::XLEN-1:0]      dat;
   logic                          is_signed;
   logic                          is_word;
   logic                          is_half;
   logic [1:0]                    bytepos;
   logic                          upper_half;

   assign ca_en     = bus.ca_vld & bus.ca_rdy;
   assign dm_en     = bus.dm_vld & bus.dm_rdy;
   assign rd_en     = bus.rd_vld & bus.rd_rdy;
   assign init_fall = init_r & !ser.init;

   assign is_signed  = !ser.funct3[2];
   assign is_word    = ser.funct3[1];
   assign is_half    = ser.funct3[0];
   assign bytepos    = adr[1:0];
   assign upper_half = bytepos[1];

   // ################################################
   // serial address adder, rs1 + imm

   assign sum = ser.rs1 ^ ser.imm ^ carry;

   always_ff @(posedge i_clk) begin
      if (i_reset | !ser.en)
         carry <= 1'b0;
      else
         carry <= (ser.rs1 & ser.imm) | (carry & (ser.rs1 ^ ser.imm));
   end

   always_ff @(posedge i_clk) begin
      if (ser.en & ser.init)
         adr <= {sum, adr[lsu_pkg::XLEN-1:1]}; // lsb arrives first
   end

   // ################################################
   // bus channels

   assign bus.ca_cmd = ser.cmd;
   assign bus.ca_adr = adr;
   assign bus.rd_rdy = !ser.en;

   // byte lanes replicated so the mask picks the right one
   assign bus.dm_dat = is_word ? dat :
                       is_half ? {2{dat[15:0]}} :
                       {4{dat[7:0]}};
   assign bus.dm_msk = is_word ? 4'b1111 :
                       is_half ? {{2{upper_half}}, ~{2{upper_half}}} :
                       4'b0001 << bytepos;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         init_r     <= 1'b0;
         ser.busy   <= 1'b0;
         bus.ca_vld <= 1'b0;
         bus.dm_vld <= 1'b0;
      end else begin
         init_r <= ser.init;

         if (ser.en & ser.init)
            ser.busy <= 1'b1;
         else if (rd_en | dm_en)
            ser.busy <= 1'b0;

         if (ca_en)
            bus.ca_vld <= 1'b0;
         else if (init_fall)
            bus.ca_vld <= 1'b1;

         if (dm_en)
            bus.dm_vld <= 1'b0;
         else if (init_fall)
            bus.dm_vld <= ser.cmd; // stores only
      end
   end

   // ################################################
   // data register, store data in and load data out

   always_ff @(posedge i_clk) begin
      if (rd_en)
         dat <= bus.rd_dat >> {bytepos, 3'b000}; // addressed byte or half to bit 0
      else if (ser.en)
         dat <= {ser.rs2, dat[lsu_pkg::XLEN-1:1]};

      if (ser.en & ser.dat_valid)
         signbit <= dat[0]; // last valid bit is the sign
   end

   assign ser.rd = ser.dat_valid ? dat[0] : (is_signed & signbit);

endmodule

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   // ################################################
   // sizes

   localparam int XLEN      = 32;
   localparam int BYTES     = XLEN / 8;          // byte lanes per word
   localparam int CNT_W     = $clog2(XLEN);      // serial bit counter
   localparam int RAM_WORDS = 256;
   localparam int RAM_AW    = $clog2(RAM_WORDS); // word address, adr[9:2]

   // ################################################
   // access width, funct3 coding
   // bit 2 unsigned, bit 1 word, bit 0 half

   typedef enum logic [2:0] {
      LSU_B  = 3'd0,
      LSU_H  = 3'd1,
      LSU_W  = 3'd2,
      LSU_BU = 3'd4,
      LSU_HU = 3'd5
   } lsu_width_e;

   // ################################################
   // sequencer states

   typedef enum logic [2:0] {
      SEQ_IDLE   = 3'd0, // waiting for a request
      SEQ_ADDR   = 3'd1, // operands shifted in, address formed
      SEQ_WAIT   = 3'd2, // bus access in flight
      SEQ_RESULT = 3'd3, // load data shifted out
      SEQ_DONE   = 3'd4  // response pulse
   } seq_state_e;

endpackage

`default_nettype wire

// ==== rtl/lsu_sequencer.sv ====
`default_nettype none

module lsu_sequencer (
   input  wire                          i_clk,
   input  wire                          i_reset,
   input  wire                          i_req_vld,
   output logic                         o_req_rdy,
   input  wire                          i_req_store,
   input  wire lsu_pkg::lsu_width_e     i_req_funct3,
   input  wire  [lsu_pkg::XLEN-1:0]     i_req_base,
   input  wire  [lsu_pkg::XLEN-1:0]     i_req_offset,
   input  wire  [lsu_pkg::XLEN-1:0]     i_req_wdata,
   output logic                         o_rsp_vld,
   output logic [lsu_pkg::XLEN-1:0]     o_rsp_data,
   lsu_serial_if.seq                    ser
);

   lsu_pkg::seq_state_e           state;
   logic [lsu_pkg::CNT_W-1:0]     bit_cnt;
   logic                          last_bit;
   logic                          req_en;
   logic                          store_q;
   lsu_pkg::lsu_width_e           width_q;
   logic [lsu_pkg::XLEN-1:0]      base_q;
   logic [lsu_pkg::XLEN-1:0]      offset_q;
   logic [lsu_pkg::XLEN-1:0]      wdata_q;
   logic [lsu_pkg::XLEN-1:0]      result_q;

   assign last_bit   = &bit_cnt;
   assign o_req_rdy  = (state == lsu_pkg::SEQ_IDLE);
   assign req_en     = i_req_vld & o_req_rdy;
   assign o_rsp_vld  = (state == lsu_pkg::SEQ_DONE);
   assign o_rsp_data = result_q;

   // ################################################
   // serial control

   assign ser.init   = (state == lsu_pkg::SEQ_ADDR);
   assign ser.en     = ser.init | (state == lsu_pkg::SEQ_RESULT);
   assign ser.cmd    = store_q;
   assign ser.funct3 = width_q;
   assign ser.rs1    = base_q[0];
   assign ser.imm    = offset_q[0];
   assign ser.rs2    = wdata_q[0];

   // bytes 0..7, halves 0..15, words all
   assign ser.dat_valid = width_q[1] |
                          (width_q[0] ? !bit_cnt[4] : (bit_cnt[4:3] == 2'b00));

   // ################################################
   // state machine

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state   <= lsu_pkg::SEQ_IDLE;
         bit_cnt <= '0;
         store_q <= 1'b0;
         width_q <= lsu_pkg::LSU_W;
      end else begin
         case (state)
            lsu_pkg::SEQ_IDLE: begin
               if (req_en) begin
                  state   <= lsu_pkg::SEQ_ADDR;
                  bit_cnt <= '0;
                  store_q <= i_req_store;
                  width_q <= i_req_funct3;
               end
            end
            lsu_pkg::SEQ_ADDR: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (last_bit)
                  state <= lsu_pkg::SEQ_WAIT;
            end
            lsu_pkg::SEQ_WAIT: begin
               if (!ser.busy)
                  state <= store_q ? lsu_pkg::SEQ_IDLE : lsu_pkg::SEQ_RESULT;
            end
            lsu_pkg::SEQ_RESULT: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (last_bit)
                  state <= lsu_pkg::SEQ_DONE;
            end
            lsu_pkg::SEQ_DONE: state <= lsu_pkg::SEQ_IDLE;
            default:           state <= lsu_pkg::SEQ_IDLE;
         endcase
      end
   end

   // ################################################
   // operand and result shift registers

   always_ff @(posedge i_clk) begin
      if (req_en) begin
         base_q   <= i_req_base;
         offset_q <= i_req_offset;
         wdata_q  <= i_req_wdata;
      end else if (ser.init) begin
         base_q   <= {1'b0, base_q[lsu_pkg::XLEN-1:1]};
         offset_q <= {1'b0, offset_q[lsu_pkg::XLEN-1:1]};
         wdata_q  <= {1'b0, wdata_q[lsu_pkg::XLEN-1:1]};
      end

      if (state == lsu_pkg::SEQ_RESULT)
         result_q <= {ser.rd, result_q[lsu_pkg::XLEN-1:1]}; // lsb first
   end

endmodule

`default_nettype wire

// ==== rtl/lsu_serial_if.sv ====
`default_nettype none

interface lsu_serial_if;

   // sequencer side
   logic                  en;        // shift enable
   logic                  init;      // address and operand phase
   logic                  dat_valid; // result bit inside access width
   logic                  cmd;       // 1 = store
   lsu_pkg::lsu_width_e   funct3;
   logic                  rs1;       // base, lsb first
   logic                  rs2;       // store data, lsb first
   logic                  imm;       // offset, lsb first

   // memory interface side
   logic                  rd;        // result bit
   logic                  busy;

   modport seq (
      output en, init, dat_valid, cmd, funct3, rs1, rs2, imm,
      input  rd, busy
   );

   modport mem (
      input  en, init, dat_valid, cmd, funct3, rs1, rs2, imm,
      output rd, busy
   );

endinterface

`default_nettype wire

// ==== rtl/serial_lsu_top.sv ====
`default_nettype none

module serial_lsu_top (
   input  wire                          i_clk,
   input  wire                          i_reset,
   input  wire                          i_req_vld,
   output logic                         o_req_rdy,
   input  wire                          i_req_store,
   input  wire lsu_pkg::lsu_width_e     i_req_funct3,
   input  wire  [lsu_pkg::XLEN-1:0]     i_req_base,
   input  wire  [lsu_pkg::XLEN-1:0]     i_req_offset,
   input  wire  [lsu_pkg::XLEN-1:0]     i_req_wdata,
   output logic                         o_rsp_vld,
   output logic [lsu_pkg::XLEN-1:0]     o_rsp_data
);

   lsu_serial_if ser ();
   dbus_if       bus ();

   // request in, serial control out
   lsu_sequencer u_sequencer (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_req_vld    (i_req_vld),
      .o_req_rdy    (o_req_rdy),
      .i_req_store  (i_req_store),
      .i_req_funct3 (i_req_funct3),
      .i_req_base   (i_req_base),
      .i_req_offset (i_req_offset),
      .i_req_wdata  (i_req_wdata),
      .o_rsp_vld    (o_rsp_vld),
      .o_rsp_data   (o_rsp_data),
      .ser          (ser.seq)
   );

   lsu_mem_if u_mem_if (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .ser     (ser.mem),
      .bus     (bus.master)
   );

   data_ram u_ram (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .bus     (bus.slave)
   );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module serial_lsu_tb -f all.f -Mdir obj_dir -o serial_lsu_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/serial_lsu_sim
if [ $? -ne 0 ]; then
   echo "simulation returned a failing status"
   exit 1
fi

exit 0

// ==== test/serial_lsu_assertions.sv ====
`default_nettype none

module serial_lsu_assertions (
   input  wire                          i_clk,
   input  wire                          i_reset,
   input  wire                          i_ca_vld,
   input  wire                          i_ca_rdy,
   input  wire  [lsu_pkg::XLEN-1:0]     i_ca_adr,
   input  wire                          i_ca_cmd,
   input  wire                          i_dm_vld,
   input  wire                          i_busy,
   input  wire                          i_rsp_vld,
   input  wire lsu_pkg::seq_state_e     i_state
);

   // ################################################
   // bus channels

   a_ca_hold : assert property (@(posedge i_clk) disable iff (i_reset)
      i_ca_vld && !i_ca_rdy |=> i_ca_vld && $stable(i_ca_adr) && $stable(i_ca_cmd))
      else $error("command valid or payload changed before ca_rdy");

   a_dm_store_only : assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(i_dm_vld) |-> i_ca_cmd)
      else $error("write data valid raised for a load");

   // ################################################
   // sequencer side

   a_rsp_pulse : assert property (@(posedge i_clk) disable iff (i_reset)
      i_rsp_vld |=> !i_rsp_vld)
      else $error("response valid held for two cycles");

   a_idle_not_busy : assert property (@(posedge i_clk) disable iff (i_reset)
      i_state == lsu_pkg::SEQ_IDLE |-> !i_busy)
      else $error("busy set while sequencer idle");

endmodule

`default_nettype wire

// ==== test/serial_lsu_tb.sv ====
`default_nettype none

module serial_lsu_tb;

   localparam int TIMEOUT_CYCLES = 200;

   logic                        clk;
   logic                        reset;
   logic                        req_vld;
   logic                        req_store;
   lsu_pkg::lsu_width_e         req_funct3;
   logic [31:0]                 req_base;
   logic [31:0]                 req_offset;
   logic [31:0]                 req_wdata;
   wire                         req_rdy;
   wire                         rsp_vld;
   wire  [31:0]                 rsp_data;

   logic [31:0]                 model [lsu_pkg::RAM_WORDS]; // expected RAM contents
   int                          rsp_seen = 0;
   int                          loads_sent = 0;
   integer                      seed;

   tb_clock u_clock (.o_clk(clk));

   serial_lsu_top uut (
      .i_clk        (clk),
      .i_reset      (reset),
      .i_req_vld    (req_vld),
      .o_req_rdy    (req_rdy),
      .i_req_store  (req_store),
      .i_req_funct3 (req_funct3),
      .i_req_base   (req_base),
      .i_req_offset (req_offset),
      .i_req_wdata  (req_wdata),
      .o_rsp_vld    (rsp_vld),
      .o_rsp_data   (rsp_data)
   );

   bind lsu_mem_if serial_lsu_assertions u_assertions (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_ca_vld  (bus.ca_vld),
      .i_ca_rdy  (bus.ca_rdy),
      .i_ca_adr  (bus.ca_adr),
      .i_ca_cmd  (bus.ca_cmd),
      .i_dm_vld  (bus.dm_vld),
      .i_busy    (ser.busy),
      .i_rsp_vld (u_sequencer.o_rsp_vld),
      .i_state   (u_sequencer.state)
   );

   always @(negedge clk) begin
      if (!reset && rsp_vld)
         rsp_seen <= rsp_seen + 1; // every response pulse
   end

   // ################################################
   // reporting

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
         fail_run($sformatf("CHECK FAILED %s expected %08h actual %08h",
                            name, expected, actual));
   endtask

   // ################################################
   // memory model

   function automatic void model_store(input logic [31:0] adr,
                                       input lsu_pkg::lsu_width_e width,
                                       input logic [31:0] data);
      case (width)
         lsu_pkg::LSU_W:                 model[adr[9:2]] = data;
         lsu_pkg::LSU_H, lsu_pkg::LSU_HU: model[adr[9:2]][16*adr[1] +: 16] = data[15:0];
         default:                        model[adr[9:2]][8*adr[1:0] +: 8] = data[7:0];
      endcase
   endfunction

   function automatic logic [31:0] model_load(input logic [31:0] adr,
                                              input lsu_pkg::lsu_width_e width);
      logic [31:0] word;
      logic [7:0]  b;
      logic [15:0] h;
      word = model[adr[9:2]];
      b    = word[8*adr[1:0] +: 8];
      h    = word[16*adr[1] +: 16];
      case (width)
         lsu_pkg::LSU_B:  return {{24{b[7]}}, b};
         lsu_pkg::LSU_BU: return {24'h0, b};
         lsu_pkg::LSU_H:  return {{16{h[15]}}, h};
         lsu_pkg::LSU_HU: return {16'h0, h};
         default:         return word;
      endcase
   endfunction

   // ################################################
   // request driving

   task automatic send_req(input logic store, input lsu_pkg::lsu_width_e width,
                           input logic [31:0] base, input logic [31:0] offset,
                           input logic [31:0] wdata);
      int n;
      @(posedge clk);
      req_vld    <= 1'b1;
      req_store  <= store;
      req_funct3 <= width;
      req_base   <= base;
      req_offset <= offset;
      req_wdata  <= wdata;
      n = 0;
      @(negedge clk);
      while (!req_rdy) begin
         n++;
         if (n > TIMEOUT_CYCLES)
            fail_run("timeout: request was never accepted");
         @(negedge clk);
      end
      @(posedge clk); // transfer edge
      req_vld <= 1'b0;
   endtask

   task automatic do_store(input lsu_pkg::lsu_width_e width, input logic [31:0] base,
                           input logic [31:0] offset, input logic [31:0] data);
      int n;
      send_req(1'b1, width, base, offset, data);
      model_store(base + offset, width, data);
      n = 0;
      @(negedge clk);
      while (!req_rdy) begin
         n++;
         if (n > TIMEOUT_CYCLES)
            fail_run("timeout: store never returned to idle");
         @(negedge clk);
      end
   endtask

   task automatic do_load(input string name, input lsu_pkg::lsu_width_e width,
                          input logic [31:0] base, input logic [31:0] offset);
      logic [31:0] expected;
      int          n;
      expected = model_load(base + offset, width);
      send_req(1'b0, width, base, offset, 32'h0);
      loads_sent++;
      n = 0;
      @(negedge clk);
      while (!rsp_vld) begin
         n++;
         if (n > TIMEOUT_CYCLES)
            fail_run($sformatf("timeout: no load response in %s", name));
         @(negedge clk);
      end
      check_value(name, expected, rsp_data);
   endtask

   // ################################################
   // directed tests

   task automatic test_reset_word();
      check_value("reset req_rdy", 32'd1, {31'd0, req_rdy});
      check_value("reset rsp_vld", 32'd0, {31'd0, rsp_vld});
      do_store(lsu_pkg::LSU_W, 32'h100, 32'h0, 32'hDEAD_BEEF);
      do_load("word store load", lsu_pkg::LSU_W, 32'h100, 32'h0);
   endtask

   task automatic test_lane_writes();
      do_store(lsu_pkg::LSU_W, 32'h40, 32'h0, 32'h0);
      for (int lane = 0; lane < 4; lane++)
         do_store(lsu_pkg::LSU_B, 32'h40, 32'(lane), 32'hFFFF_FF00 | 32'(8'h11 * (lane + 1)));
      do_load("byte lanes", lsu_pkg::LSU_W, 32'h40, 32'h0);
      do_store(lsu_pkg::LSU_W, 32'h44, 32'h0, 32'h1234_5678);
      do_store(lsu_pkg::LSU_H, 32'h44, 32'h0, 32'hAAAA_BEEF);
      do_load("lower half", lsu_pkg::LSU_W, 32'h44, 32'h0);
      do_store(lsu_pkg::LSU_H, 32'h44, 32'h2, 32'h5555_CAFE);
      do_load("upper half", lsu_pkg::LSU_W, 32'h44, 32'h0);
   endtask

   task automatic test_extension();
      do_store(lsu_pkg::LSU_W, 32'h80, 32'h0, 32'h7F80_8001); // top bits set and clear
      for (int lane = 0; lane < 4; lane++) begin
         do_load("LSU_B",  lsu_pkg::LSU_B,  32'h80, 32'(lane));
         do_load("LSU_BU", lsu_pkg::LSU_BU, 32'h80, 32'(lane));
      end
      for (int half = 0; half < 4; half += 2) begin
         do_load("LSU_H",  lsu_pkg::LSU_H,  32'h80, 32'(half));
         do_load("LSU_HU", lsu_pkg::LSU_HU, 32'h80, 32'(half));
      end
   endtask

   task automatic test_address_carry();
      do_store(lsu_pkg::LSU_W, 32'h200, 32'hFFFF_FFF8, 32'h0BAD_F00D);
      do_load("negative offset", lsu_pkg::LSU_W, 32'h1F0, 32'h8);
      do_store(lsu_pkg::LSU_W, 32'h0000_FFF0, 32'h0000_0024, 32'h1357_9BDF);
      do_load("carry past bit 16", lsu_pkg::LSU_W, 32'h14, 32'h0);
      do_store(lsu_pkg::LSU_W, 32'h2C0, 32'h0, 32'h2468_ACE0);
      do_load("carry and wrap", lsu_pkg::LSU_W, 32'h0001_02C4, 32'hFFFF_FFFC);
   endtask

   function automatic lsu_pkg::lsu_width_e pick_width(input int k);
      case (k)
         0:       return lsu_pkg::LSU_B;
         1:       return lsu_pkg::LSU_H;
         3:       return lsu_pkg::LSU_BU;
         4:       return lsu_pkg::LSU_HU;
         default: return lsu_pkg::LSU_W;
      endcase
   endfunction

   task automatic test_random();
      logic [31:0]         r;
      logic [31:0]         adr;
      logic [31:0]         offset;
      int                  k;
      lsu_pkg::lsu_width_e width;
      for (int i = 0; i < 16; i++) begin
         adr = 32'h300 + 32'(4 * i);
         do_store(lsu_pkg::LSU_W, adr, 32'h0, adr ^ (adr << 13) ^ 32'hA5C3_0F1E);
      end
      for (int i = 0; i < 40; i++) begin
         r      = $random(seed);
         offset = $random(seed);
         k      = int'(r[10:8]) % 5;
         if (r[11] && k > 2)
            k = k - 3; // stores have no unsigned widths
         width = pick_width(k);
         adr   = 32'h300 + {26'd0, r[5:2], 2'b00};
         if (k == 1 || k == 4)
            adr[1] = r[1];
         else if (k == 0 || k == 3)
            adr[1:0] = r[1:0];
         if (r[11])
            do_store(width, adr - offset, offset, $random(seed));
         else
            do_load($sformatf("random op %0d", i), width, adr - offset, offset);
      end
      @(posedge clk);
      check_value("response count", 32'(loads_sent), 32'(rsp_seen));
   endtask

   initial begin
      seed = 63305;
      reset      <= 1'b1;
      req_vld    <= 1'b0;
      req_store  <= 1'b0;
      req_funct3 <= lsu_pkg::LSU_W;
      req_base   <= 32'h0;
      req_offset <= 32'h0;
      req_wdata  <= 32'h0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      test_reset_word();
      test_lane_writes();
      test_extension();
      test_address_carry();
      test_random();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
   output logic o_clk
);

   initial o_clk = 1'b0;

   always #5 o_clk = ~o_clk; // period 10

endmodule

`default_nettype wire
